/* cv_pkg.sv */
// Console bus controller shared types, memory map and I/O port map
package cv_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------

  // CPU address and data
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  data_t;

  // Cartridge ROM address, 64 pages of 16 KB
  typedef logic [19:0] cart_addr_t;
  typedef logic [5:0]  page_t;

  // Raw controller lines, all active low
  // Bit 0 up, 1 right, 2 down, 3 left, 4 left fire
  typedef logic [4:0]  joy_t;
  typedef logic [3:0]  key_t;

  // Controller connector mode
  typedef enum logic {
    CTRL_KEYPAD   = 1'b0,
    CTRL_JOYSTICK = 1'b1
  } ctrl_mode_e;

  // ------------------------------
  // Memory map
  // ------------------------------

  // Top three address bits of the BIOS, 0x0000-0x1FFF
  localparam logic [2:0] BIOS_BASE_NIB = 3'b000;
  // Top three address bits of the RAM, 0x6000-0x7FFF
  localparam logic [2:0] RAM_BASE_NIB  = 3'b011;
  // Cartridge lives in the upper half, 0x8000-0xFFFF
  // The two bits below pick the 8 KB window
  localparam int CART_BASE_BIT = 15;

  // Reads from here up switch the cartridge page
  localparam addr_t PAGE_SEL_BASE = 16'hFFC0;

  // ------------------------------
  // I/O port groups, A7..A5
  // ------------------------------

  localparam logic [2:0] PORT_KEY_MODE = 3'b100;
  localparam logic [2:0] PORT_VDP      = 3'b101;
  localparam logic [2:0] PORT_JOY_MODE = 3'b110;
  // Write goes to the PSG, read returns controller data
  localparam logic [2:0] PORT_PSG_CTRL = 3'b111;

  // ------------------------------
  // Misc
  // ------------------------------

  // 10.7 MHz enables per CPU enable, gives 3.58 MHz
  localparam int CPU_CEN_DIV = 3;

  // Pulled-up data bus
  localparam data_t BUS_IDLE = 8'hFF;

endpackage

/* cv_cpu_timing.sv */
// CPU clock enable divider and M1 wait state generator
`timescale 1ns/10ps

module cv_cpu_timing (
  input  logic clk_i,
  input  logic reset_n_s,
  // 10.7 MHz enable from the board clock
  input  logic clk_en_10m7_i,
  input  logic m1_n_i,
  input  logic psg_ready_i,
  output logic cpu_cen_o,
  output logic wait_n_o
);

  localparam int CNT_W = $clog2(cv_pkg::CPU_CEN_DIV);

  // Enable counter, wraps after the last step
  logic [CNT_W-1:0] div_q;
  logic             div_last_s;
  // Extra wait cycle for every opcode fetch
  logic             m1_wait_q;

  // ------------------------------
  // Clock enable divider
  // ------------------------------

  assign div_last_s = (div_q == CNT_W'(cv_pkg::CPU_CEN_DIV - 1));

  always_ff @(posedge clk_i or negedge reset_n_s)
  begin
    if (!reset_n_s)
    begin
      div_q <= '0;
    end
    else if (clk_en_10m7_i)
    begin
      // Count only on the fast enable
      div_q <= div_last_s ? '0 : div_q + 1'b1;
    end
  end

  // Pulse coincides with every third fast enable
  assign cpu_cen_o = clk_en_10m7_i & div_last_s;

  // ------------------------------
  // M1 wait flip-flop
  // ------------------------------

  always_ff @(posedge clk_i or negedge reset_n_s)
  begin
    if (!reset_n_s)
    begin
      m1_wait_q <= 1'b0;
    end
    else if (m1_n_i)
    begin
      // Held clear outside fetch cycles
      m1_wait_q <= 1'b0;
    end
    else if (cpu_cen_o)
    begin
      m1_wait_q <= ~m1_wait_q;
    end
  end

  // Wait while flag set or PSG busy
  assign wait_n_o = psg_ready_i & ~m1_wait_q;

endmodule

/* cv_addr_dec.sv */
// Memory and I/O address decoder with active-low chip selects
`timescale 1ns/10ps

module cv_addr_dec (
  input  cv_pkg::addr_t addr_i,
  input  logic          mreq_n_i,
  input  logic          iorq_n_i,
  input  logic          rd_n_i,
  input  logic          wr_n_i,
  input  logic          m1_n_i,
  input  logic          rfsh_n_i,
  // Memory selects
  output logic          bios_ce_n_o,
  output logic          ram_ce_n_o,
  output logic [3:0]    cart_en_n_o,
  // I/O selects
  output logic          vdp_r_n_o,
  output logic          vdp_w_n_o,
  output logic          psg_we_n_o,
  output logic          ctrl_r_n_o,
  output logic          ctrl_key_wr_n_o,
  output logic          ctrl_joy_wr_n_o,
  // Read in the page select area
  output logic          page_sel_o
);

  localparam int CB = cv_pkg::CART_BASE_BIT;

  logic       mem_acc_s;
  logic       mem_rd_s;
  logic       cart_rd_s;
  logic       io_rd_s;
  logic       io_wr_s;
  logic [2:0] port_grp_s;

  // ------------------------------
  // Cycle qualification
  // ------------------------------

  // Refresh drives mreq too, so mask it
  assign mem_acc_s = ~mreq_n_i & rfsh_n_i;
  assign mem_rd_s  = mem_acc_s & ~rd_n_i;

  // iorq with m1 low is an interrupt acknowledge
  assign io_rd_s = ~iorq_n_i & m1_n_i & ~rd_n_i;
  assign io_wr_s = ~iorq_n_i & m1_n_i & ~wr_n_i;

  // Only A7..A5 are decoded on I/O
  assign port_grp_s = addr_i[7:5];

  // ------------------------------
  // Memory map
  // ------------------------------

  // BIOS and RAM follow the region, read or write
  assign bios_ce_n_o = ~(mem_acc_s && addr_i[15:13] == cv_pkg::BIOS_BASE_NIB);
  assign ram_ce_n_o  = ~(mem_acc_s && addr_i[15:13] == cv_pkg::RAM_BASE_NIB);

  // Cartridge is ROM, reads only
  assign cart_rd_s = mem_rd_s & addr_i[CB];

  always_comb
  begin
    // One enable per 8 KB window
    for (int w = 0; w < 4; w++)
    begin
      cart_en_n_o[w] = ~(cart_rd_s && addr_i[CB-1:CB-2] == w[1:0]);
    end
  end

  // Top 64 bytes of the map switch the page
  assign page_sel_o = mem_rd_s && (addr_i >= cv_pkg::PAGE_SEL_BASE);

  // ------------------------------
  // I/O map
  // ------------------------------

  // VDP has separate read and write strobes
  assign vdp_r_n_o = ~(io_rd_s && port_grp_s == cv_pkg::PORT_VDP);
  assign vdp_w_n_o = ~(io_wr_s && port_grp_s == cv_pkg::PORT_VDP);

  // Group 111 is shared, PSG on write and controller on read
  assign psg_we_n_o = ~(io_wr_s && port_grp_s == cv_pkg::PORT_PSG_CTRL);
  assign ctrl_r_n_o = ~(io_rd_s && port_grp_s == cv_pkg::PORT_PSG_CTRL);

  // Mode switch strobes, data is ignored
  assign ctrl_key_wr_n_o = ~(io_wr_s && port_grp_s == cv_pkg::PORT_KEY_MODE);
  assign ctrl_joy_wr_n_o = ~(io_wr_s && port_grp_s == cv_pkg::PORT_JOY_MODE);

endmodule

/* cv_cart_mapper.sv */
// Cartridge page register and 20-bit cartridge address generation
`timescale 1ns/10ps

module cv_cart_mapper (
  input  logic               clk_i,
  input  logic               reset_n_s,
  input  cv_pkg::addr_t      addr_i,
  input  logic               mreq_n_i,
  input  logic               rd_n_i,
  // Memory read at or above the page select base
  input  logic               page_sel_i,
  // Page mask of the inserted cartridge, zero for plain carts
  input  cv_pkg::page_t      cart_pages_i,
  output cv_pkg::cart_addr_t cart_a_o,
  output logic               cart_rd_o
);

  localparam int CB = cv_pkg::CART_BASE_BIT;

  // Page mapped into 0xC000-0xFFFF
  cv_pkg::page_t page_q;
  logic          paging_on_s;

  // ------------------------------
  // Page register
  // ------------------------------

  assign paging_on_s = |cart_pages_i;

  always_ff @(posedge clk_i or negedge reset_n_s)
  begin
    if (!reset_n_s)
    begin
      page_q <= '0;
    end
    else if (page_sel_i && paging_on_s)
    begin
      // Mask to the pages that exist
      page_q <= addr_i[5:0] & cart_pages_i;
    end
  end

  // ------------------------------
  // Address generation
  // ------------------------------

  // Lower 16 KB fixed on page 0, upper 16 KB switched
  assign cart_a_o = addr_i[CB-1] ? {page_q, addr_i[13:0]}
                                 : {6'd0, addr_i[13:0]};

  // Any read in the cartridge half
  assign cart_rd_o = addr_i[CB] & ~mreq_n_i & ~rd_n_i;

endmodule

/* cv_ctrl.sv */
// Controller port mode register and controller read byte formatting
`timescale 1ns/10ps

module cv_ctrl (
  input  logic          clk_i,
  input  logic          reset_n_s,
  // Mode strobes from the port decoder
  input  logic          key_wr_n_i,
  input  logic          joy_wr_n_i,
  // Low reads player 1, high reads player 2
  input  logic          a1_i,
  input  cv_pkg::joy_t  p1_joy_n_i,
  input  cv_pkg::key_t  p1_key_n_i,
  input  logic          p1_fire_r_n_i,
  input  cv_pkg::joy_t  p2_joy_n_i,
  input  cv_pkg::key_t  p2_key_n_i,
  input  logic          p2_fire_r_n_i,
  // Common lines of both connectors
  output logic          key_sel_n_o,
  output logic          joy_sel_n_o,
  output cv_pkg::data_t d_o
);

  cv_pkg::ctrl_mode_e mode_q;

  // Lines of the addressed player
  cv_pkg::joy_t joy_s;
  cv_pkg::key_t key_s;
  logic         fire_r_s;

  // ------------------------------
  // Mode register
  // ------------------------------

  always_ff @(posedge clk_i or negedge reset_n_s)
  begin
    if (!reset_n_s)
    begin
      mode_q <= cv_pkg::CTRL_KEYPAD;
    end
    else if (!key_wr_n_i)
    begin
      mode_q <= cv_pkg::CTRL_KEYPAD;
    end
    else if (!joy_wr_n_i)
    begin
      mode_q <= cv_pkg::CTRL_JOYSTICK;
    end
  end

  // One half of the controller is powered at a time
  assign key_sel_n_o = (mode_q != cv_pkg::CTRL_KEYPAD);
  assign joy_sel_n_o = (mode_q != cv_pkg::CTRL_JOYSTICK);

  // ------------------------------
  // Read byte
  // ------------------------------

  assign joy_s    = a1_i ? p2_joy_n_i : p1_joy_n_i;
  assign key_s    = a1_i ? p2_key_n_i : p1_key_n_i;
  assign fire_r_s = a1_i ? p2_fire_r_n_i : p1_fire_r_n_i;

  always_comb
  begin
    if (mode_q == cv_pkg::CTRL_JOYSTICK)
    begin
      // Left fire in bit 6, directions in the low nibble
      d_o = {1'b1, joy_s[4], 2'b11, joy_s[3], joy_s[2], joy_s[1], joy_s[0]};
    end
    else
    begin
      // Right fire in bit 6, key code in the low nibble
      d_o = {1'b1, fire_r_s, 2'b11, key_s};
    end
  end

endmodule

/* cv_bus_mux.sv */
// Read data multiplexer toward the CPU
`timescale 1ns/10ps

module cv_bus_mux (
  input  logic          bios_ce_n_i,
  input  logic          ram_ce_n_i,
  input  logic [3:0]    cart_en_n_i,
  input  logic          vdp_r_n_i,
  input  logic          ctrl_r_n_i,
  input  logic          rd_n_i,
  input  cv_pkg::data_t bios_d_i,
  input  cv_pkg::data_t ram_d_i,
  input  cv_pkg::data_t cart_d_i,
  input  cv_pkg::data_t vdp_d_i,
  input  cv_pkg::data_t ctrl_d_i,
  output cv_pkg::data_t d_o
);

  logic cart_sel_s;

  // Any of the four windows
  assign cart_sel_s = ~&cart_en_n_i;

  always_comb
  begin
    // Memory selects also cover writes, so qualify by rd
    if (!rd_n_i && !bios_ce_n_i)
    begin
      d_o = bios_d_i;
    end
    else if (!rd_n_i && !ram_ce_n_i)
    begin
      d_o = ram_d_i;
    end
    else if (!rd_n_i && cart_sel_s)
    begin
      d_o = cart_d_i;
    end
    else if (!vdp_r_n_i)
    begin
      d_o = vdp_d_i;
    end
    else if (!ctrl_r_n_i)
    begin
      d_o = ctrl_d_i;
    end
    else
    begin
      d_o = cv_pkg::BUS_IDLE;
    end
  end

endmodule

/* cv_console.sv */
// Console bus controller top level joining timing, decode, mapper, controller and mux
`timescale 1ns/10ps

module cv_console (
  input  logic               clk_i,
  input  logic               reset_n_s,
  input  logic               clk_en_10m7_i,
  // CPU bus
  input  cv_pkg::addr_t      addr_i,
  input  cv_pkg::data_t      data_i,
  input  logic               mreq_n_i,
  input  logic               iorq_n_i,
  input  logic               rd_n_i,
  input  logic               wr_n_i,
  input  logic               m1_n_i,
  input  logic               rfsh_n_i,
  output cv_pkg::data_t      data_o,
  output logic               cpu_cen_o,
  output logic               wait_n_o,
  // Write data toward RAM, VDP and PSG
  output cv_pkg::data_t      bus_d_o,
  // BIOS and RAM
  output logic               bios_ce_n_o,
  input  cv_pkg::data_t      bios_d_i,
  output logic               ram_ce_n_o,
  output logic [14:0]        ram_a_o,
  input  cv_pkg::data_t      ram_d_i,
  // Cartridge
  input  cv_pkg::page_t      cart_pages_i,
  output logic [3:0]         cart_en_n_o,
  output cv_pkg::cart_addr_t cart_a_o,
  output logic               cart_rd_o,
  input  cv_pkg::data_t      cart_d_i,
  // VDP and PSG
  output logic               vdp_r_n_o,
  output logic               vdp_w_n_o,
  input  cv_pkg::data_t      vdp_d_i,
  output logic               psg_we_n_o,
  input  logic               psg_ready_i,
  // Controllers
  input  cv_pkg::joy_t       p1_joy_n_i,
  input  cv_pkg::key_t       p1_key_n_i,
  input  logic               p1_fire_r_n_i,
  input  cv_pkg::joy_t       p2_joy_n_i,
  input  cv_pkg::key_t       p2_key_n_i,
  input  logic               p2_fire_r_n_i,
  output logic               key_sel_n_o,
  output logic               joy_sel_n_o
);

  logic          ctrl_r_n_s;
  logic          ctrl_key_wr_n_s;
  logic          ctrl_joy_wr_n_s;
  logic          page_sel_s;
  cv_pkg::data_t ctrl_d_s;

  assign ram_a_o = addr_i[14:0];
  assign bus_d_o = data_i;

  // ------------------------------
  // Clock enable and wait
  // ------------------------------

  cv_cpu_timing timing_i (
    .clk_i(clk_i), .reset_n_s(reset_n_s), .clk_en_10m7_i(clk_en_10m7_i),
    .m1_n_i(m1_n_i), .psg_ready_i(psg_ready_i),
    .cpu_cen_o(cpu_cen_o), .wait_n_o(wait_n_o)
  );

  // ------------------------------
  // Decode and mapper
  // ------------------------------

  cv_addr_dec addr_dec_i (
    .addr_i(addr_i), .mreq_n_i(mreq_n_i), .iorq_n_i(iorq_n_i),
    .rd_n_i(rd_n_i), .wr_n_i(wr_n_i), .m1_n_i(m1_n_i), .rfsh_n_i(rfsh_n_i),
    .bios_ce_n_o(bios_ce_n_o), .ram_ce_n_o(ram_ce_n_o), .cart_en_n_o(cart_en_n_o),
    .vdp_r_n_o(vdp_r_n_o), .vdp_w_n_o(vdp_w_n_o), .psg_we_n_o(psg_we_n_o),
    .ctrl_r_n_o(ctrl_r_n_s), .ctrl_key_wr_n_o(ctrl_key_wr_n_s),
    .ctrl_joy_wr_n_o(ctrl_joy_wr_n_s), .page_sel_o(page_sel_s)
  );

  cv_cart_mapper mapper_i (
    .clk_i(clk_i), .reset_n_s(reset_n_s), .addr_i(addr_i),
    .mreq_n_i(mreq_n_i), .rd_n_i(rd_n_i), .page_sel_i(page_sel_s),
    .cart_pages_i(cart_pages_i), .cart_a_o(cart_a_o), .cart_rd_o(cart_rd_o)
  );

  // ------------------------------
  // Controllers and read mux
  // ------------------------------

  // A1 picks the player
  cv_ctrl ctrl_i (
    .clk_i(clk_i), .reset_n_s(reset_n_s),
    .key_wr_n_i(ctrl_key_wr_n_s), .joy_wr_n_i(ctrl_joy_wr_n_s), .a1_i(addr_i[1]),
    .p1_joy_n_i(p1_joy_n_i), .p1_key_n_i(p1_key_n_i), .p1_fire_r_n_i(p1_fire_r_n_i),
    .p2_joy_n_i(p2_joy_n_i), .p2_key_n_i(p2_key_n_i), .p2_fire_r_n_i(p2_fire_r_n_i),
    .key_sel_n_o(key_sel_n_o), .joy_sel_n_o(joy_sel_n_o), .d_o(ctrl_d_s)
  );

  cv_bus_mux bus_mux_i (
    .bios_ce_n_i(bios_ce_n_o), .ram_ce_n_i(ram_ce_n_o), .cart_en_n_i(cart_en_n_o),
    .vdp_r_n_i(vdp_r_n_o), .ctrl_r_n_i(ctrl_r_n_s), .rd_n_i(rd_n_i),
    .bios_d_i(bios_d_i), .ram_d_i(ram_d_i), .cart_d_i(cart_d_i),
    .vdp_d_i(vdp_d_i), .ctrl_d_i(ctrl_d_s), .d_o(data_o)
  );

endmodule

/* tb_cv_console.sv */
// Self-checking testbench for the console bus controller
`timescale 1ns/10ps

module tb_cv_console;

  localparam int CLK_NS = 4;

  // Bus cycle kinds
  localparam int K_IDLE = 0;
  localparam int K_MRD  = 1;
  localparam int K_MWR  = 2;
  localparam int K_RFSH = 3;
  localparam int K_IORD = 4;
  localparam int K_IOWR = 5;
  localparam int K_INTA = 6;

  // Cycles per test, sets the watchdog
  localparam int N_MEM       = 200;
  localparam int N_IO        = 256 * 3;
  localparam int N_MUX       = 300;
  localparam int N_CTRL      = 5 * 6;
  localparam int N_MAP       = (8 + 8 + 4) * 3;
  localparam int N_TIME      = 300;
  localparam int RUN_CYCLES  = 4 + N_MEM + N_IO + N_MUX + N_CTRL + N_MAP + N_TIME;
  localparam int WATCHDOG_NS = (RUN_CYCLES + 200) * CLK_NS;

  logic clk_i;
  logic reset_n_s;
  logic clk_en_10m7_i;
  cv_pkg::addr_t addr_i;
  cv_pkg::data_t data_i, data_o, bus_d_o;
  logic mreq_n_i, iorq_n_i, rd_n_i, wr_n_i, m1_n_i, rfsh_n_i;
  logic cpu_cen_o, wait_n_o, psg_ready_i;
  logic bios_ce_n_o, ram_ce_n_o, cart_rd_o;
  logic [14:0] ram_a_o;
  logic [3:0] cart_en_n_o;
  cv_pkg::data_t bios_d_i, ram_d_i, cart_d_i, vdp_d_i;
  cv_pkg::page_t cart_pages_i;
  cv_pkg::cart_addr_t cart_a_o;
  logic vdp_r_n_o, vdp_w_n_o, psg_we_n_o;
  cv_pkg::joy_t p1_joy_n_i, p2_joy_n_i;
  cv_pkg::key_t p1_key_n_i, p2_key_n_i;
  logic p1_fire_r_n_i, p2_fire_r_n_i, key_sel_n_o, joy_sel_n_o;

  // Reference state, kept from the bus rules
  logic          joy_mode_m;
  cv_pkg::page_t page_m;
  cv_pkg::page_t pages_v;
  logic          m1_flag_m;
  logic          exp_cen;
  int            en_cnt;
  // Bookkeeping
  integer        seed = 32'h1574_19ad;
  logic [31:0]   rnd;
  int            i, kind;
  int            checks, errors, sva_errors, n_tests, chk_base, err_base;

  cv_console dut_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  // CPU enable is a single-clock pulse, the divider restarts after it
  cen_single_cycle: assert property (@(posedge clk_i) disable iff (!reset_n_s)
                                     cpu_cen_o |=> !cpu_cen_o)
    else
    begin
      $display("cpu_cen_o stayed high for two cycles at %0t", $time);
      sva_errors++;
    end

  // ------------------------------
  // Check helpers
  // ------------------------------

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %0d %s: %0d checks, %0d errors", n_tests + 1, name,
             checks - chk_base, errors - err_base);
    n_tests++;
    chk_base = checks;
    err_base = errors;
  endtask

  // Controller byte of the addressed player
  function automatic cv_pkg::data_t ctrl_byte(input logic a1);
    cv_pkg::joy_t j;
    cv_pkg::key_t k;
    logic         f;
    j = a1 ? p2_joy_n_i : p1_joy_n_i;
    k = a1 ? p2_key_n_i : p1_key_n_i;
    f = a1 ? p2_fire_r_n_i : p1_fire_r_n_i;
    if (joy_mode_m)
      return {1'b1, j[4], 1'b1, 1'b1, j[3], j[2], j[1], j[0]};
    else
      return {1'b1, f, 1'b1, 1'b1, k};
  endfunction

  task automatic check_outputs(input int kind, input cv_pkg::addr_t a);
    logic          mem;
    logic [3:0]    exp_cart;
    logic [2:0]    grp;
    int            ai;
    int            lo;
    int            exp_ca;
    cv_pkg::data_t exp_d;
    mem = (kind == K_MRD) || (kind == K_MWR);
    grp = a[7:5];
    ai  = int'(a);
    // Four 8 KB windows from 0x8000
    for (int w = 0; w < 4; w++)
    begin
      lo = 'h8000 + w * 'h2000;
      exp_cart[w] = !(kind == K_MRD && ai >= lo && ai < lo + 'h2000);
    end
    exp_d = cv_pkg::BUS_IDLE;
    if (kind == K_MRD)
    begin
      if (ai < 'h2000) exp_d = bios_d_i;
      else if (ai >= 'h6000 && ai < 'h8000) exp_d = ram_d_i;
      else if (ai >= 'h8000) exp_d = cart_d_i;
    end
    else if (kind == K_IORD && grp == 3'b101) exp_d = vdp_d_i;
    else if (kind == K_IORD && grp == 3'b111) exp_d = ctrl_byte(a[1]);
    check_val("bios_ce_n_o", 32'(bios_ce_n_o), 32'(!(mem && ai < 'h2000)));
    check_val("ram_ce_n_o", 32'(ram_ce_n_o), 32'(!(mem && ai >= 'h6000 && ai < 'h8000)));
    check_val("cart_en_n_o", 32'(cart_en_n_o), 32'(exp_cart));
    check_val("cart_rd_o", 32'(cart_rd_o), 32'(kind == K_MRD && ai >= 'h8000));
    check_val("vdp_r_n_o", 32'(vdp_r_n_o), 32'(!(kind == K_IORD && grp == 3'b101)));
    check_val("vdp_w_n_o", 32'(vdp_w_n_o), 32'(!(kind == K_IOWR && grp == 3'b101)));
    check_val("psg_we_n_o", 32'(psg_we_n_o), 32'(!(kind == K_IOWR && grp == 3'b111)));
    check_val("data_o", 32'(data_o), 32'(exp_d));
    check_val("ram_a_o", 32'(ram_a_o), 32'(a[14:0]));
    check_val("bus_d_o", 32'(bus_d_o), 32'(data_i));
    // Keypad mode pulls key_sel low
    check_val("key_sel_n_o", 32'(key_sel_n_o), 32'(joy_mode_m));
    check_val("joy_sel_n_o", 32'(joy_sel_n_o), 32'(!joy_mode_m));
    if (ai >= 'h8000)
    begin
      // Upper 16 KB on the current page, lower on page 0
      exp_ca = (ai >= 'hC000) ? int'(page_m) * 'h4000 + ai % 'h4000 : ai % 'h4000;
      check_val("cart_a_o", 32'(cart_a_o), exp_ca);
    end
  endtask

  // ------------------------------
  // Bus cycle driver
  // ------------------------------

  task automatic drive_cycle(input int kind, input cv_pkg::addr_t a);
    @(negedge clk_i);
    rnd = $random(seed);
    // Bit 7 clear keeps memory bytes apart from idle and controller bytes
    bios_d_i      = {1'b0, rnd[6:0]};
    ram_d_i       = bios_d_i ^ 8'h21;
    cart_d_i      = bios_d_i ^ 8'h42;
    vdp_d_i       = bios_d_i ^ 8'h63;
    data_i        = rnd[15:8];
    p1_joy_n_i    = rnd[20:16];
    p1_key_n_i    = rnd[24:21];
    p1_fire_r_n_i = rnd[25];
    p2_joy_n_i    = rnd[30:26];
    p2_fire_r_n_i = rnd[31];
    rnd = $random(seed);
    p2_key_n_i    = rnd[3:0];
    cart_pages_i  = pages_v;
    addr_i        = a;
    mreq_n_i      = !(kind == K_MRD || kind == K_MWR || kind == K_RFSH);
    iorq_n_i      = !(kind == K_IORD || kind == K_IOWR || kind == K_INTA);
    // Interrupt acknowledge with rd low as a worst case
    rd_n_i        = !(kind == K_MRD || kind == K_IORD || kind == K_INTA);
    wr_n_i        = !(kind == K_MWR || kind == K_IOWR);
    m1_n_i        = (kind != K_INTA);
    rfsh_n_i      = (kind != K_RFSH);
    #1;
    check_outputs(kind, a);
    // Registers take the cycle at the coming rising edge
    if (kind == K_IOWR && a[7:5] == 3'b100) joy_mode_m = 1'b0;
    if (kind == K_IOWR && a[7:5] == 3'b110) joy_mode_m = 1'b1;
    if (kind == K_MRD && a >= 16'hFFC0 && cart_pages_i != 6'd0)
      page_m = a[5:0] & cart_pages_i;
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial
  begin
    reset_n_s = 1'b0;
    clk_en_10m7_i = 1'b0;
    addr_i = '0;
    data_i = '0;
    {mreq_n_i, iorq_n_i, rd_n_i, wr_n_i, m1_n_i, rfsh_n_i} = 6'b111111;
    psg_ready_i = 1'b1;
    {bios_d_i, ram_d_i, cart_d_i, vdp_d_i} = '0;
    cart_pages_i = '0;
    {p1_joy_n_i, p2_joy_n_i, p1_key_n_i, p2_key_n_i} = '1;
    {p1_fire_r_n_i, p2_fire_r_n_i} = 2'b11;
    {joy_mode_m, page_m, pages_v, m1_flag_m, en_cnt} = '0;
    {checks, errors, sva_errors, n_tests, chk_base, err_base} = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_n_s = 1'b1;

    // Idle after reset, then random memory cycles
    drive_cycle(K_IDLE, 16'h0000);
    check_val("wait_n_o", 32'(wait_n_o), 32'(psg_ready_i));
    check_val("cpu_cen_o", 32'(cpu_cen_o), 32'(1'b0));
    repeat (N_MEM)
    begin
      rnd = $random(seed);
      kind = K_MRD + int'(rnd[7:0] % 8'd3);
      drive_cycle(kind, rnd[31:16]);
    end
    end_test("memory decode");

    for (i = 0; i < 256; i++)
    begin
      rnd = $random(seed);
      drive_cycle(K_IORD, {rnd[15:8], 8'(i)});
      drive_cycle(K_IOWR, {rnd[15:8], 8'(i)});
      drive_cycle(K_INTA, {rnd[15:8], 8'(i)});
    end
    end_test("io decode");

    repeat (N_MUX)
    begin
      rnd = $random(seed);
      kind = (rnd[1:0] < 2'd2) ? K_MRD + int'(rnd[1:0]) : K_IORD + int'(rnd[0]);
      drive_cycle(kind, rnd[31:16]);
    end
    end_test("read mux");

    // Alternate modes, read both players after each switch
    repeat (5)
    begin
      drive_cycle(K_IOWR, 16'h0080);
      drive_cycle(K_IORD, 16'h00E0);
      drive_cycle(K_IORD, 16'h00E2);
      drive_cycle(K_IOWR, 16'h00C0);
      drive_cycle(K_IORD, 16'h00E0);
      drive_cycle(K_IORD, 16'h00E2);
    end
    end_test("controller");

    for (i = 0; i < 20; i++)
    begin
      // Plain cartridge, then a 16-page mega cartridge
      // Last rounds plain again, so the switched page has to hold
      pages_v = (i >= 8 && i < 16) ? 6'h0F : 6'h00;
      rnd = $random(seed);
      drive_cycle(K_MRD, 16'hFFC0 | {10'd0, rnd[5:0]});
      drive_cycle(K_MRD, {2'b11, rnd[21:8]});
      drive_cycle(K_MRD, {2'b10, rnd[21:8]});
    end
    end_test("cart mapper");

    for (i = 0; i < N_TIME; i++)
    begin
      @(negedge clk_i);
      rnd = $random(seed);
      clk_en_10m7_i = rnd[0] | rnd[1];
      psg_ready_i   = (rnd[4:2] != 3'd0);
      // Fetch cycles of nine clocks
      m1_n_i        = ((i / 9) % 2 == 0);
      exp_cen       = clk_en_10m7_i && (en_cnt == cv_pkg::CPU_CEN_DIV - 1);
      #1;
      check_val("cpu_cen_o", 32'(cpu_cen_o), 32'(exp_cen));
      check_val("wait_n_o", 32'(wait_n_o), 32'(psg_ready_i && !m1_flag_m));
      if (clk_en_10m7_i) en_cnt = (en_cnt == cv_pkg::CPU_CEN_DIV - 1) ? 0 : en_cnt + 1;
      if (m1_n_i) m1_flag_m = 1'b0;
      else if (exp_cen) m1_flag_m = !m1_flag_m;
    end
    end_test("cpu timing");

    $display("Summary: %0d tests, %0d checks, %0d errors, %0d property errors",
             n_tests, checks, errors, sva_errors);
    if (errors + sva_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* list.f */
cv_pkg.sv
cv_cpu_timing.sv
cv_addr_dec.sv
cv_cart_mapper.sv
cv_ctrl.sv
cv_bus_mux.sv
cv_console.sv
tb_cv_console.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert --timing -f list.f --top-module tb_cv_console \
		-Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
